/* hw/dispatch_pkg.sv */
package dispatch_pkg;

	localparam int DATA_W = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_GR = 32;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [4:0] cmd_t;

	// System register space
	localparam reg_addr_t SYSREG_CPUIDR = 5'h00;
	localparam reg_addr_t SYSREG_COREIDR = 5'h01;
	localparam reg_addr_t SYSREG_TIDR = 5'h02;
	localparam reg_addr_t SYSREG_PCR = 5'h04;
	localparam reg_addr_t SYSREG_SPR = 5'h05;
	localparam reg_addr_t SYSREG_PSR = 5'h06;
	localparam reg_addr_t SYSREG_IDTR = 5'h07;
	localparam reg_addr_t SYSREG_PDTR = 5'h09;
	localparam reg_addr_t SYSREG_PPSR = 5'h0d;

	// Processor id in the upper half, revision in the lower
	localparam data_t PROCESSOR_ID_REV = 32'h0001_0003;

	// PSR bits 6, 5 and 2
	localparam data_t PSR_IRQ_CLEAR_MASK = 32'h0000_0064;

endpackage

/* hw/dispatch_top.sv */
`timescale 1ns/10ps

module dispatch_top #(
	parameter dispatch_pkg::data_t CORE_ID = '0,
	parameter int NUM_CREDITS = 4
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic in_valid,
	output logic in_ready,
	input dispatch_pkg::cmd_t in_cmd,
	input dispatch_pkg::reg_addr_t in_destination,
	input logic in_dest_sysreg,
	input logic in_writeback,
	input logic in_src0_sysreg,
	input logic in_src1_sysreg,
	input logic in_src1_imm,
	input dispatch_pkg::reg_addr_t in_src0,
	input dispatch_pkg::data_t in_src1,
	input dispatch_pkg::data_t in_pc,
	input logic wb_valid,
	input dispatch_pkg::reg_addr_t wb_destination,
	input logic wb_dest_sysreg,
	input logic wb_writeback,
	input dispatch_pkg::data_t wb_data,
	input logic wb_spr_writeback,
	input dispatch_pkg::data_t wb_spr,
	input logic irq_set,
	input logic irq_clear,
	output logic out_valid,
	output dispatch_pkg::cmd_t out_cmd,
	output dispatch_pkg::reg_addr_t out_destination,
	output logic out_dest_sysreg,
	output logic out_writeback,
	output dispatch_pkg::data_t out_source0,
	output dispatch_pkg::data_t out_source1,
	output dispatch_pkg::data_t out_pc,
	input logic credit_return,
	output dispatch_pkg::data_t sysreg_psr,
	output dispatch_pkg::data_t sysreg_ppsr
);

	dispatch_pkg::data_t gr_data0, gr_data1;
	dispatch_pkg::data_t sr_data0, sr_data1;
	logic sr_hit0, sr_hit1;

	gr_file u_gr_file (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.wb_valid(wb_valid),
		.wb_writeback(wb_writeback),
		.wb_dest_sysreg(wb_dest_sysreg),
		.wb_destination(wb_destination),
		.wb_data(wb_data),
		.rd_addr0(in_src0),
		.rd_addr1(in_src1[dispatch_pkg::REG_ADDR_W-1:0]),
		.rd_data0(gr_data0),
		.rd_data1(gr_data1)
	);

	sysreg_file #(
		.CORE_ID(CORE_ID)
	) u_sysreg_file (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.wb_valid(wb_valid),
		.wb_writeback(wb_writeback),
		.wb_dest_sysreg(wb_dest_sysreg),
		.wb_spr_writeback(wb_spr_writeback),
		.wb_destination(wb_destination),
		.wb_data(wb_data),
		.wb_spr(wb_spr),
		.irq_set(irq_set),
		.irq_clear(irq_clear),
		.rd_addr0(in_src0),
		.rd_addr1(in_src1[dispatch_pkg::REG_ADDR_W-1:0]),
		.pc(in_pc),
		.rd_data0(sr_data0),
		.rd_data1(sr_data1),
		.rd_hit0(sr_hit0),
		.rd_hit1(sr_hit1),
		.sysreg_psr(sysreg_psr),
		.sysreg_ppsr(sysreg_ppsr)
	);

	issue_stage #(
		.NUM_CREDITS(NUM_CREDITS)
	) u_issue_stage (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_cmd(in_cmd),
		.in_destination(in_destination),
		.in_dest_sysreg(in_dest_sysreg),
		.in_writeback(in_writeback),
		.in_src0_sysreg(in_src0_sysreg),
		.in_src1_sysreg(in_src1_sysreg),
		.in_src1_imm(in_src1_imm),
		.in_src1(in_src1),
		.in_pc(in_pc),
		.gr_data0(gr_data0),
		.gr_data1(gr_data1),
		.sr_data0(sr_data0),
		.sr_data1(sr_data1),
		.sr_hit0(sr_hit0),
		.sr_hit1(sr_hit1),
		.out_valid(out_valid),
		.out_cmd(out_cmd),
		.out_destination(out_destination),
		.out_dest_sysreg(out_dest_sysreg),
		.out_writeback(out_writeback),
		.out_source0(out_source0),
		.out_source1(out_source1),
		.out_pc(out_pc),
		.credit_return(credit_return)
	);

endmodule

/* hw/gr_file.sv */
`timescale 1ns/10ps

module gr_file (
	input logic iCLOCK,
	input logic inRESET,
	input logic wb_valid,
	input logic wb_writeback,
	input logic wb_dest_sysreg,
	input dispatch_pkg::reg_addr_t wb_destination,
	input dispatch_pkg::data_t wb_data,
	input dispatch_pkg::reg_addr_t rd_addr0,
	input dispatch_pkg::reg_addr_t rd_addr1,
	output dispatch_pkg::data_t rd_data0,
	output dispatch_pkg::data_t rd_data1
);

	dispatch_pkg::data_t regs [dispatch_pkg::NUM_GR];
	logic wr_en;

	assign wr_en = wb_valid && wb_writeback && !wb_dest_sysreg;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < dispatch_pkg::NUM_GR; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb_destination] <= wb_data;
		end
	end

	// Same-cycle write bypass
	always_comb begin
		if (wr_en && wb_destination == rd_addr0) begin
			rd_data0 = wb_data;
		end else begin
			rd_data0 = regs[rd_addr0];
		end
		if (wr_en && wb_destination == rd_addr1) begin
			rd_data1 = wb_data;
		end else begin
			rd_data1 = regs[rd_addr1];
		end
	end

	wb_dest_known: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		wb_valid |-> !$isunknown(wb_destination)
	) else $error("gr_file: unknown writeback destination");

endmodule

/* hw/issue_stage.sv */
`timescale 1ns/10ps

module issue_stage #(
	parameter int NUM_CREDITS = 4
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic in_valid,
	output logic in_ready,
	input dispatch_pkg::cmd_t in_cmd,
	input dispatch_pkg::reg_addr_t in_destination,
	input logic in_dest_sysreg,
	input logic in_writeback,
	input logic in_src0_sysreg,
	input logic in_src1_sysreg,
	input logic in_src1_imm,
	input dispatch_pkg::data_t in_src1,
	input dispatch_pkg::data_t in_pc,
	input dispatch_pkg::data_t gr_data0,
	input dispatch_pkg::data_t gr_data1,
	input dispatch_pkg::data_t sr_data0,
	input dispatch_pkg::data_t sr_data1,
	input logic sr_hit0,
	input logic sr_hit1,
	output logic out_valid,
	output dispatch_pkg::cmd_t out_cmd,
	output dispatch_pkg::reg_addr_t out_destination,
	output logic out_dest_sysreg,
	output logic out_writeback,
	output dispatch_pkg::data_t out_source0,
	output dispatch_pkg::data_t out_source1,
	output dispatch_pkg::data_t out_pc,
	input logic credit_return
);

	localparam int CNT_W = $clog2(NUM_CREDITS + 1);

	logic [CNT_W-1:0] credit_cnt;
	logic accept;
	dispatch_pkg::data_t src0_sel, src1_sel;

	assign in_ready = credit_cnt != '0;
	assign accept = in_valid && in_ready;

	// Missed sysreg reads give zero
	always_comb begin
		if (in_src0_sysreg) begin
			src0_sel = sr_hit0 ? sr_data0 : '0;
		end else begin
			src0_sel = gr_data0;
		end
		if (in_src1_imm) begin
			src1_sel = in_src1;
		end else if (in_src1_sysreg) begin
			src1_sel = sr_hit1 ? sr_data1 : '0;
		end else begin
			src1_sel = gr_data1;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			credit_cnt <= CNT_W'(NUM_CREDITS);
			out_valid <= 1'b0;
		end else begin
			out_valid <= accept;
			if (accept && !credit_return) begin
				credit_cnt <= credit_cnt - 1'b1;
			end else if (!accept && credit_return) begin
				credit_cnt <= credit_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			out_cmd <= in_cmd;
			out_destination <= in_destination;
			out_dest_sysreg <= in_dest_sysreg;
			out_writeback <= in_writeback;
			out_source0 <= src0_sel;
			out_source1 <= src1_sel;
			out_pc <= in_pc;
		end
	end

	credit_bound: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		credit_cnt <= CNT_W'(NUM_CREDITS)
	) else $error("issue_stage: credit count above limit");

	// Downstream only returns slots it was given
	return_needs_issue: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		credit_return |-> credit_cnt != CNT_W'(NUM_CREDITS)
	) else $error("issue_stage: credit returned with all credits home");

endmodule

/* hw/sysreg_file.sv */
`timescale 1ns/10ps

module sysreg_file #(
	parameter dispatch_pkg::data_t CORE_ID = '0
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic wb_valid,
	input logic wb_writeback,
	input logic wb_dest_sysreg,
	input logic wb_spr_writeback,
	input dispatch_pkg::reg_addr_t wb_destination,
	input dispatch_pkg::data_t wb_data,
	input dispatch_pkg::data_t wb_spr,
	input logic irq_set,
	input logic irq_clear,
	input dispatch_pkg::reg_addr_t rd_addr0,
	input dispatch_pkg::reg_addr_t rd_addr1,
	input dispatch_pkg::data_t pc,
	output dispatch_pkg::data_t rd_data0,
	output dispatch_pkg::data_t rd_data1,
	output logic rd_hit0,
	output logic rd_hit1,
	output dispatch_pkg::data_t sysreg_psr,
	output dispatch_pkg::data_t sysreg_ppsr
);

	dispatch_pkg::data_t tidr_q, psr_q, ppsr_q, spr_q, idtr_q, pdtr_q;
	dispatch_pkg::data_t tidr_d, psr_d, ppsr_d, spr_d, idtr_d, pdtr_d;
	dispatch_pkg::data_t pcr;
	logic wr_en;

	assign wr_en = wb_valid && wb_writeback && wb_dest_sysreg;
	assign pcr = pc - dispatch_pkg::data_t'(4);

	// Next state, IRQ moves win over writeback
	always_comb begin
		tidr_d = (wr_en && wb_destination == dispatch_pkg::SYSREG_TIDR) ? wb_data : tidr_q;
		idtr_d = (wr_en && wb_destination == dispatch_pkg::SYSREG_IDTR) ? wb_data : idtr_q;
		pdtr_d = (wr_en && wb_destination == dispatch_pkg::SYSREG_PDTR) ? wb_data : pdtr_q;
		if (wb_valid && wb_spr_writeback) begin
			spr_d = wb_spr;
		end else if (wr_en && wb_destination == dispatch_pkg::SYSREG_SPR) begin
			spr_d = wb_data;
		end else begin
			spr_d = spr_q;
		end
		if (irq_set) begin
			psr_d = psr_q & ~dispatch_pkg::PSR_IRQ_CLEAR_MASK;
		end else if (irq_clear) begin
			psr_d = ppsr_q;
		end else if (wr_en && wb_destination == dispatch_pkg::SYSREG_PSR) begin
			psr_d = wb_data;
		end else begin
			psr_d = psr_q;
		end
		if (irq_set) begin
			ppsr_d = psr_q;
		end else if (wr_en && wb_destination == dispatch_pkg::SYSREG_PPSR) begin
			ppsr_d = wb_data;
		end else begin
			ppsr_d = ppsr_q;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			tidr_q <= '0;
			psr_q <= '0;
			ppsr_q <= '0;
			spr_q <= '0;
			idtr_q <= '0;
			pdtr_q <= '0;
		end else begin
			tidr_q <= tidr_d;
			psr_q <= psr_d;
			ppsr_q <= ppsr_d;
			spr_q <= spr_d;
			idtr_q <= idtr_d;
			pdtr_q <= pdtr_d;
		end
	end

	// Hit flag on top of the value
	function automatic logic [dispatch_pkg::DATA_W:0] read_sysreg(
		input dispatch_pkg::reg_addr_t idx
	);
		case (idx)
			dispatch_pkg::SYSREG_CPUIDR: return {1'b1, dispatch_pkg::PROCESSOR_ID_REV};
			dispatch_pkg::SYSREG_COREIDR: return {1'b1, CORE_ID};
			dispatch_pkg::SYSREG_TIDR: return {1'b1, tidr_d};
			dispatch_pkg::SYSREG_PCR: return {1'b1, pcr};
			dispatch_pkg::SYSREG_SPR: return {1'b1, spr_d};
			dispatch_pkg::SYSREG_PSR: return {1'b1, psr_d};
			dispatch_pkg::SYSREG_IDTR: return {1'b1, idtr_d};
			dispatch_pkg::SYSREG_PDTR: return {1'b1, pdtr_d};
			dispatch_pkg::SYSREG_PPSR: return {1'b1, ppsr_d};
			default: return '0;
		endcase
	endfunction

	always_comb begin
		{rd_hit0, rd_data0} = read_sysreg(rd_addr0);
		{rd_hit1, rd_data1} = read_sysreg(rd_addr1);
	end

	assign sysreg_psr = psr_q;
	assign sysreg_ppsr = ppsr_q;

	irq_exclusive: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!(irq_set && irq_clear)
	) else $error("sysreg_file: irq_set and irq_clear together");

endmodule

/* run.sh */
#!/bin/sh
# Build and run the dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_dispatch -o tb_dispatch
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_dispatch)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1

/* sources.f */
+incdir+verification
hw/dispatch_pkg.sv
hw/gr_file.sv
hw/sysreg_file.sv
hw/issue_stage.sv
hw/dispatch_top.sv
verification/tb_dispatch.sv

/* verification/dispatch_model.svh */
`ifndef DISPATCH_MODEL_SVH
`define DISPATCH_MODEL_SVH

// Model state after the writes of the last committed cycle
dispatch_pkg::data_t m_gr [dispatch_pkg::NUM_GR];
dispatch_pkg::data_t m_sr [32];
int m_credits;

function automatic bit sr_writable(input dispatch_pkg::reg_addr_t idx);
	return idx == dispatch_pkg::SYSREG_TIDR || idx == dispatch_pkg::SYSREG_SPR ||
		idx == dispatch_pkg::SYSREG_PSR || idx == dispatch_pkg::SYSREG_IDTR ||
		idx == dispatch_pkg::SYSREG_PDTR || idx == dispatch_pkg::SYSREG_PPSR;
endfunction

task automatic model_reset(input int credits);
	foreach (m_gr[i]) m_gr[i] = '0;
	foreach (m_sr[i]) m_sr[i] = '0;
	m_credits = credits;
endtask

task automatic model_write(
	input logic valid,
	input logic writeback,
	input logic dest_sys,
	input dispatch_pkg::reg_addr_t dest,
	input dispatch_pkg::data_t data,
	input logic spr_wb,
	input dispatch_pkg::data_t spr,
	input logic set,
	input logic clear
);
	dispatch_pkg::data_t old_psr;
	dispatch_pkg::data_t old_ppsr;
	old_psr = m_sr[dispatch_pkg::SYSREG_PSR];
	old_ppsr = m_sr[dispatch_pkg::SYSREG_PPSR];
	if (valid && writeback && !dest_sys) m_gr[dest] = data;
	if (valid && writeback && dest_sys && sr_writable(dest)) m_sr[dest] = data;
	if (valid && spr_wb) m_sr[dispatch_pkg::SYSREG_SPR] = spr;
	// IRQ moves override any writeback to PSR or PPSR
	if (set) begin
		m_sr[dispatch_pkg::SYSREG_PPSR] = old_psr;
		m_sr[dispatch_pkg::SYSREG_PSR] = old_psr & ~dispatch_pkg::PSR_IRQ_CLEAR_MASK;
	end
	if (clear) m_sr[dispatch_pkg::SYSREG_PSR] = old_ppsr;
endtask

function automatic dispatch_pkg::data_t model_read(
	input logic sys,
	input dispatch_pkg::reg_addr_t idx,
	input dispatch_pkg::data_t pc,
	input dispatch_pkg::data_t core_id
);
	if (!sys) return m_gr[idx];
	if (idx == dispatch_pkg::SYSREG_CPUIDR) return dispatch_pkg::PROCESSOR_ID_REV;
	if (idx == dispatch_pkg::SYSREG_COREIDR) return core_id;
	if (idx == dispatch_pkg::SYSREG_PCR) return pc - 32'd4;
	if (sr_writable(idx)) return m_sr[idx];
	return '0;
endfunction

task automatic model_credit(input logic accept, input logic ret);
	m_credits = m_credits - int'(accept) + int'(ret);
endtask

`endif

/* verification/tb_dispatch.sv */
`timescale 1ns/10ps

module tb_dispatch;

	localparam dispatch_pkg::data_t CORE_ID = 32'h0000_00a5;
	localparam int NUM_CREDITS = 4;
	localparam int WAIT_LIMIT = 200;

	logic iCLOCK;
	logic inRESET;
	logic in_valid;
	logic in_ready;
	dispatch_pkg::cmd_t in_cmd;
	dispatch_pkg::reg_addr_t in_destination;
	logic in_dest_sysreg, in_writeback, in_src0_sysreg, in_src1_sysreg, in_src1_imm;
	dispatch_pkg::reg_addr_t in_src0;
	dispatch_pkg::data_t in_src1, in_pc;
	logic wb_valid, wb_dest_sysreg, wb_writeback, wb_spr_writeback;
	dispatch_pkg::reg_addr_t wb_destination;
	dispatch_pkg::data_t wb_data, wb_spr;
	logic irq_set, irq_clear;
	logic out_valid;
	dispatch_pkg::cmd_t out_cmd;
	dispatch_pkg::reg_addr_t out_destination;
	logic out_dest_sysreg, out_writeback;
	dispatch_pkg::data_t out_source0, out_source1, out_pc;
	logic credit_return;
	dispatch_pkg::data_t sysreg_psr, sysreg_ppsr;

	// Expected issues in acceptance order
	dispatch_pkg::data_t exp_src0_q[$];
	dispatch_pkg::data_t exp_src1_q[$];
	logic [63:0] exp_fields_q[$];
	logic exp_valid;
	int outstanding;
	int errors, checks, tests, test_errs;
	string test_name;

	`include "dispatch_model.svh"

	dispatch_top #(.CORE_ID(CORE_ID), .NUM_CREDITS(NUM_CREDITS)) DUT (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #20 iCLOCK = ~iCLOCK;
	end

	task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (act === exp) else begin
			$display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
			test_errs++;
		end
	endtask

	task automatic report_failure(input string why);
		$display("Test %s: %s", test_name, why);
		errors++;
		test_errs++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		tests++;
		$display("Test %s: %0d errors", test_name, test_errs);
	endtask

	task automatic check_outputs();
		dispatch_pkg::data_t src0;
		dispatch_pkg::data_t src1;
		logic [63:0] fields;
		check_value("out_valid", exp_valid, out_valid);
		if (out_valid) begin
			outstanding++;
			assert (outstanding <= NUM_CREDITS) else begin
				$display("Test %s: downstream holds %0d instructions but has only %0d slots",
					test_name, outstanding, NUM_CREDITS);
				errors++;
				test_errs++;
			end
		end
		if (exp_valid) begin
			src0 = exp_src0_q.pop_front();
			src1 = exp_src1_q.pop_front();
			fields = exp_fields_q.pop_front();
			check_value("source0", src0, out_source0);
			check_value("source1", src1, out_source1);
			check_value("fields", fields, {20'h0, out_cmd, out_destination, out_dest_sysreg,
				out_writeback, out_pc});
		end
		check_value("in_ready", m_credits > 0, in_ready);
		check_value("sysreg_psr", m_sr[dispatch_pkg::SYSREG_PSR], sysreg_psr);
		check_value("sysreg_ppsr", m_sr[dispatch_pkg::SYSREG_PPSR], sysreg_ppsr);
	endtask

	// Commit this cycle's inputs to the model, then move to the next falling edge
	task automatic next_cycle();
		logic accept;
		accept = in_valid && m_credits > 0;
		model_write(wb_valid, wb_writeback, wb_dest_sysreg, wb_destination, wb_data,
			wb_spr_writeback, wb_spr, irq_set, irq_clear);
		if (accept) begin
			exp_src0_q.push_back(model_read(in_src0_sysreg, in_src0, in_pc, CORE_ID));
			if (in_src1_imm) begin
				exp_src1_q.push_back(in_src1);
			end else begin
				exp_src1_q.push_back(model_read(in_src1_sysreg,
					in_src1[dispatch_pkg::REG_ADDR_W-1:0], in_pc, CORE_ID));
			end
			exp_fields_q.push_back({20'h0, in_cmd, in_destination, in_dest_sysreg,
				in_writeback, in_pc});
		end
		model_credit(accept, credit_return);
		exp_valid = accept;
		@(negedge iCLOCK);
		check_outputs();
		// Upstream holds a refused instruction
		if (accept) in_valid = 1'b0;
		wb_valid = 1'b0;
		wb_writeback = 1'b0;
		wb_spr_writeback = 1'b0;
		irq_set = 1'b0;
		irq_clear = 1'b0;
		credit_return = 1'b0;
		if (outstanding > 0 && $urandom_range(0, 2) == 0) begin
			credit_return = 1'b1;
			outstanding--;
		end
	endtask

	task automatic drive_instr(
		input logic src0_sys,
		input dispatch_pkg::reg_addr_t src0,
		input logic src1_sys,
		input logic src1_imm,
		input dispatch_pkg::data_t src1,
		input dispatch_pkg::data_t pc
	);
		in_valid = 1'b1;
		in_cmd = 5'($urandom());
		in_destination = 5'($urandom());
		in_dest_sysreg = 1'($urandom());
		in_writeback = 1'($urandom());
		in_src0_sysreg = src0_sys;
		in_src0 = src0;
		in_src1_sysreg = src1_sys;
		in_src1_imm = src1_imm;
		in_src1 = src1;
		in_pc = pc;
	endtask

	task automatic drive_wb(
		input logic sys,
		input dispatch_pkg::reg_addr_t dest,
		input dispatch_pkg::data_t data,
		input logic spr_wb,
		input dispatch_pkg::data_t spr
	);
		wb_valid = 1'b1;
		wb_writeback = 1'b1;
		wb_dest_sysreg = sys;
		wb_destination = dest;
		wb_data = data;
		wb_spr_writeback = spr_wb;
		wb_spr = spr;
	endtask

	task automatic wait_accepted();
		int waited;
		waited = 0;
		while (in_valid && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		assert (!in_valid) else report_failure("instruction was never accepted");
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while ((in_valid || exp_valid || outstanding > 0) && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		assert (!in_valid && outstanding == 0) else report_failure("downstream never drained");
	endtask

	task automatic test_reset();
		start_test("reset");
		check_value("out_valid", 1'b0, out_valid);
		check_value("in_ready", 1'b1, in_ready);
		check_value("sysreg_psr", 32'h0, sysreg_psr);
		check_value("sysreg_ppsr", 32'h0, sysreg_ppsr);
		drive_instr(1'b0, 5'd7, 1'b1, 1'b0, 32'(dispatch_pkg::SYSREG_TIDR), 32'h100);
		wait_accepted();
		drive_instr(1'b1, dispatch_pkg::SYSREG_SPR, 1'b0, 1'b0, 32'd31, 32'h104);
		wait_accepted();
		drain();
		finish_test();
	endtask

	task automatic test_gr_rw();
		start_test("gr_write_read");
		for (int i = 1; i < 6; i++) begin
			drive_wb(1'b0, 5'(i * 3), 32'hc0de_0000 + 32'(i), 1'b0, '0);
			next_cycle();
		end
		drive_instr(1'b0, 5'd3, 1'b0, 1'b0, 32'd6, 32'h200);
		wait_accepted();
		drive_instr(1'b0, 5'd15, 1'b0, 1'b0, 32'd9, 32'h204);
		wait_accepted();
		drain();
		finish_test();
	endtask

	task automatic test_forwarding();
		start_test("forwarding");
		drive_instr(1'b0, 5'd9, 1'b0, 1'b0, 32'd9, 32'h300);
		drive_wb(1'b0, 5'd9, 32'h1357_9bdf, 1'b0, '0);
		wait_accepted();
		drive_instr(1'b1, dispatch_pkg::SYSREG_TIDR, 1'b0, 1'b0, 32'd9, 32'h304);
		drive_wb(1'b1, dispatch_pkg::SYSREG_TIDR, 32'h2468_ace0, 1'b0, '0);
		wait_accepted();
		// wb_spr wins over a wb_data write to SPR
		drive_instr(1'b1, dispatch_pkg::SYSREG_SPR, 1'b1, 1'b0, 32'(dispatch_pkg::SYSREG_SPR),
			32'h308);
		drive_wb(1'b1, dispatch_pkg::SYSREG_SPR, 32'hdead_0001, 1'b1, 32'h0bad_f00d);
		wait_accepted();
		drain();
		finish_test();
	endtask

	task automatic test_sysregs();
		start_test("immediates_sysregs");
		drive_instr(1'b1, dispatch_pkg::SYSREG_CPUIDR, 1'b1, 1'b0,
			32'(dispatch_pkg::SYSREG_COREIDR), 32'h400);
		wait_accepted();
		drive_instr(1'b1, dispatch_pkg::SYSREG_PCR, 1'b1, 1'b0, 32'h1f, 32'h0000_1000);
		wait_accepted();
		drive_instr(1'b1, 5'h0e, 1'b1, 1'b1, 32'hdead_beef, 32'h408);
		wait_accepted();
		drain();
		finish_test();
	endtask

	task automatic test_irq();
		dispatch_pkg::data_t old_psr;
		start_test("irq_mode");
		old_psr = 32'h0000_00ff;
		drive_wb(1'b1, dispatch_pkg::SYSREG_PSR, old_psr, 1'b0, '0);
		next_cycle();
		irq_set = 1'b1;
		next_cycle();
		check_value("ppsr after irq_set", old_psr, sysreg_ppsr);
		check_value("psr after irq_set", old_psr & ~dispatch_pkg::PSR_IRQ_CLEAR_MASK, sysreg_psr);
		drive_wb(1'b1, dispatch_pkg::SYSREG_PSR, 32'h1234_5678, 1'b0, '0);
		next_cycle();
		irq_clear = 1'b1;
		next_cycle();
		check_value("ppsr after irq_clear", old_psr, sysreg_ppsr);
		check_value("psr restored", old_psr, sysreg_psr);
		drive_instr(1'b1, dispatch_pkg::SYSREG_PSR, 1'b1, 1'b0, 32'(dispatch_pkg::SYSREG_PPSR),
			32'h500);
		drive_wb(1'b1, dispatch_pkg::SYSREG_PSR, 32'hffff_ffff, 1'b0, '0);
		irq_set = 1'b1;
		wait_accepted();
		drain();
		finish_test();
	endtask

	task automatic test_random();
		int r;
		start_test("random_traffic");
		for (int i = 0; i < 400; i++) begin
			if ($urandom_range(0, 1) == 1) begin
				drive_wb(1'($urandom()), 5'($urandom_range(0, 15)), $urandom(),
					$urandom_range(0, 4) == 0, $urandom());
			end
			r = $urandom_range(0, 9);
			if (r == 0) irq_set = 1'b1;
			else if (r == 1) irq_clear = 1'b1;
			if (!in_valid && $urandom_range(0, 9) < 7) begin
				drive_instr(1'($urandom()), 5'($urandom_range(0, 15)), 1'($urandom()),
					$urandom_range(0, 3) == 0, $urandom_range(0, 15), $urandom());
			end
			next_cycle();
		end
		drain();
		finish_test();
	endtask

	initial begin
		void'($urandom(23));
		errors = 0;
		checks = 0;
		tests = 0;
		outstanding = 0;
		exp_valid = 1'b0;
		test_name = "startup";
		inRESET = 1'b0;
		in_valid = 1'b0;
		in_cmd = '0;
		in_destination = '0;
		in_dest_sysreg = 1'b0;
		in_writeback = 1'b0;
		in_src0_sysreg = 1'b0;
		in_src1_sysreg = 1'b0;
		in_src1_imm = 1'b0;
		in_src0 = '0;
		in_src1 = '0;
		in_pc = '0;
		wb_valid = 1'b0;
		wb_dest_sysreg = 1'b0;
		wb_writeback = 1'b0;
		wb_spr_writeback = 1'b0;
		wb_destination = '0;
		wb_data = '0;
		wb_spr = '0;
		irq_set = 1'b0;
		irq_clear = 1'b0;
		credit_return = 1'b0;
		model_reset(NUM_CREDITS);
		repeat (2) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		test_reset();
		test_gr_rw();
		test_forwarding();
		test_sysregs();
		test_irq();
		test_random();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
